// File: source/lsu_pkg.sv
// --------------------------------------------------
// load/store unit package
// widths, operator codes, records, byte-enable helpers
// --------------------------------------------------
`default_nettype none

package lsu_pkg;

    // data path and tag widths
    localparam int unsigned XLEN               = 32;
    localparam int unsigned TRANS_ID_BITS      = 3;
    // write-back delay per port
    localparam int unsigned NR_LOAD_PIPE_REGS  = 1;
    localparam int unsigned NR_STORE_PIPE_REGS = 2;

    // exception causes, privileged spec encoding
    localparam logic [XLEN-1:0] LD_ADDR_MISALIGNED = 32'd4;
    localparam logic [XLEN-1:0] ST_ADDR_MISALIGNED = 32'd6;

    typedef enum logic [1:0] {LOAD, STORE, NONE} fu_t;

    typedef enum logic [2:0] {LB, LBU, LH, LHU, LW, SB, SH, SW} fu_op_t;

    // issued operation
    typedef struct packed {
        fu_t                      fu;
        fu_op_t                   operator;
        logic [XLEN-1:0]          operand_a;
        // store data
        logic [XLEN-1:0]          operand_b;
        logic [11:0]              imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] cause;
        // faulting address
        logic [XLEN-1:0] tval;
    } exception_t;

    // control record passed between stages
    typedef struct packed {
        logic                     valid;
        logic [XLEN-1:0]          vaddr;
        logic [XLEN-1:0]          data;
        logic [3:0]               be;
        fu_t                      fu;
        fu_op_t                   operator;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    // write-back record
    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        exception_t               ex;
    } lsu_result_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [3:0]      be;
        logic [XLEN-1:0] wdata;
    } dmem_req_t;

    // size code: 00 byte, 01 half, 10 word
    function automatic logic [1:0] extract_transfer_size(fu_op_t op);
        case (op)
            LB, LBU, SB: return 2'b00;
            LH, LHU, SH: return 2'b01;
            default:     return 2'b10;
        endcase
    endfunction

    // lanes touched by an access at the given byte offset
    function automatic logic [3:0] be_gen(logic [1:0] addr, logic [1:0] size);
        case (size)
            2'b00:   return 4'b0001 << addr;
            2'b01:   return 4'b0011 << addr;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: source/lsu_agu.sv
// --------------------------------------------------
// address generation stage
// builds the control record from the issued operation
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  lsu_pkg::fu_data_t  fu_data_i,
    input  logic               lsu_valid_i,
    output lsu_pkg::lsu_ctrl_t lsu_req_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] vaddr;
    logic [3:0]      be;

    // --------------------------------------------------
    // virtual address
    // --------------------------------------------------
    // 12-bit immediate, sign extended to xlen
    assign imm_sext = {{(XLEN-12){fu_data_i.imm[11]}}, fu_data_i.imm};
    // no translation, vaddr goes straight to memory
    assign vaddr    = fu_data_i.operand_a + imm_sext;

    // lanes from low address bits and size
    assign be = be_gen(vaddr[1:0], extract_transfer_size(fu_data_i.operator));

    // --------------------------------------------------
    // control record
    // --------------------------------------------------
    always_comb begin
        lsu_req_o          = '0;
        lsu_req_o.valid    = lsu_valid_i;
        lsu_req_o.vaddr    = vaddr;
        // unshifted store data, lane shift happens at the port
        lsu_req_o.data     = fu_data_i.operand_b;
        lsu_req_o.be       = be;
        lsu_req_o.fu       = fu_data_i.fu;
        lsu_req_o.operator = fu_data_i.operator;
        lsu_req_o.trans_id = fu_data_i.trans_id;
    end

endmodule

`default_nettype wire

// File: source/lsu_bypass.sv
// --------------------------------------------------
// two-entry bypass FIFO for load/store requests
// head stays stable while the memory stalls
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_bypass (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  lsu_pkg::lsu_ctrl_t lsu_req_i,
    input  logic               lsu_req_valid_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,
    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
    output logic               ready_o
);
    import lsu_pkg::*;

    lsu_ctrl_t [1:0] mem_d, mem_q;
    logic            rd_ptr_d, rd_ptr_q;
    logic            wr_ptr_d, wr_ptr_q;
    logic [1:0]      cnt_d, cnt_q;
    logic            empty;

    assign empty   = (cnt_q == 2'd0);
    // accept only into an empty buffer
    assign ready_o = empty;

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        mem_d    = mem_q;
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;
        // every valid request is sampled
        if (lsu_req_valid_i) begin
            mem_d[wr_ptr_q] = lsu_req_i;
            wr_ptr_d        = ~wr_ptr_q;
            cnt_d           = cnt_d + 2'd1;
        end
        // head retires from the same slot as a write when empty
        if (pop_ld_i || pop_st_i) begin
            mem_d[rd_ptr_q].valid = 1'b0;
            rd_ptr_d              = ~rd_ptr_q;
            cnt_d                 = cnt_d - 2'd1;
        end
    end

    // pass-through when nothing is queued
    assign lsu_ctrl_o = empty ? lsu_req_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    // request storage
    always_ff @(posedge clk_i) begin
        mem_q <= mem_d;
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(lsu_req_valid_i && cnt_q == 2'd2));
    a_single_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i));

endmodule

`default_nettype wire

// File: source/lsu_access.sv
// --------------------------------------------------
// memory access stage
// misalignment check, memory port, load extension
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_access (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  lsu_pkg::lsu_ctrl_t     lsu_ctrl_i,
    input  logic                   dmem_gnt_i,
    input  logic [lsu_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                   pop_ld_o,
    output logic                   pop_st_o,
    output lsu_pkg::dmem_req_t     dmem_req_o,
    output lsu_pkg::lsu_result_t   ld_result_o,
    output lsu_pkg::lsu_result_t   st_result_o
);
    import lsu_pkg::*;

    logic [1:0]      size;
    logic            is_load;
    logic            is_store;
    logic            misaligned;
    logic            done;
    logic [4:0]      lane_shift;
    logic [XLEN-1:0] rdata_shifted;
    logic [XLEN-1:0] ld_data;
    exception_t      mis_ex;
    lsu_result_t     ld_result_d, ld_result_q;
    lsu_result_t     st_result_d, st_result_q;

    assign size       = extract_transfer_size(lsu_ctrl_i.operator);
    assign is_load    = lsu_ctrl_i.valid && (lsu_ctrl_i.fu == LOAD);
    assign is_store   = lsu_ctrl_i.valid && (lsu_ctrl_i.fu == STORE);
    // byte offset in bits
    assign lane_shift = {lsu_ctrl_i.vaddr[1:0], 3'b000};

    // --------------------------------------------------
    // misaligned exception
    // --------------------------------------------------
    always_comb begin
        case (size)
            2'b10:   misaligned = |lsu_ctrl_i.vaddr[1:0];
            2'b01:   misaligned = lsu_ctrl_i.vaddr[0];
            // bytes never misalign
            default: misaligned = 1'b0;
        endcase
        mis_ex       = '0;
        mis_ex.valid = misaligned && (is_load || is_store);
        mis_ex.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
        mis_ex.tval  = lsu_ctrl_i.vaddr;
    end

    // --------------------------------------------------
    // memory port
    // --------------------------------------------------
    always_comb begin
        // no request for a faulting access
        dmem_req_o.req   = (is_load || is_store) && !misaligned;
        dmem_req_o.we    = is_store;
        dmem_req_o.addr  = {lsu_ctrl_i.vaddr[XLEN-1:2], 2'b00};
        dmem_req_o.be    = lsu_ctrl_i.be;
        // store data into its byte lanes
        dmem_req_o.wdata = lsu_ctrl_i.data << lane_shift;
    end

    // head retires on fault or grant
    assign done     = (is_load || is_store) && (misaligned || dmem_gnt_i);
    assign pop_ld_o = is_load && done;
    assign pop_st_o = is_store && done;

    // --------------------------------------------------
    // load data extension
    // --------------------------------------------------
    assign rdata_shifted = dmem_rdata_i >> lane_shift;

    always_comb begin
        case (lsu_ctrl_i.operator)
            LB:      ld_data = {{(XLEN-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
            LBU:     ld_data = {{(XLEN-8){1'b0}}, rdata_shifted[7:0]};
            LH:      ld_data = {{(XLEN-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
            LHU:     ld_data = {{(XLEN-16){1'b0}}, rdata_shifted[15:0]};
            default: ld_data = rdata_shifted;
        endcase
    end

    // --------------------------------------------------
    // result records
    // --------------------------------------------------
    always_comb begin
        ld_result_d          = '0;
        ld_result_d.valid    = pop_ld_o;
        ld_result_d.trans_id = lsu_ctrl_i.trans_id;
        // faulting load returns zero
        ld_result_d.result   = misaligned ? '0 : ld_data;
        ld_result_d.ex       = mis_ex;
        st_result_d          = '0;
        st_result_d.valid    = pop_st_o;
        st_result_d.trans_id = lsu_ctrl_i.trans_id;
        st_result_d.ex       = mis_ex;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ld_result_q <= '0;
            st_result_q <= '0;
        end else begin
            ld_result_q <= ld_result_d;
            st_result_q <= st_result_d;
        end
    end

    assign ld_result_o = ld_result_q;
    assign st_result_o = st_result_q;

    // held request relies on the bypass FIFO keeping its head
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmem_req_o.req && !dmem_gnt_i |=> $stable(dmem_req_o));

endmodule

`default_nettype wire

// File: source/lsu_pipe_reg.sv
// --------------------------------------------------
// write-back delay line, Depth register stages
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_reg #(
    parameter int unsigned Depth = 1
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  lsu_pkg::lsu_result_t d_i,
    output lsu_pkg::lsu_result_t d_o
);
    import lsu_pkg::*;

    // stage 0 takes the input, last stage drives the output
    lsu_result_t [Depth-1:0] shift_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            shift_q <= '0;
        end else begin
            shift_q[0] <= d_i;
            for (int i = 1; i < Depth; i++) begin
                shift_q[i] <= shift_q[i-1];
            end
        end
    end

    assign d_o = shift_q[Depth-1];

endmodule

`default_nettype wire

// File: source/load_store_unit.sv
// --------------------------------------------------
// load/store unit top
// agu, bypass FIFO, access stage and output delays
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     lsu_valid_i,
    input  lsu_pkg::fu_data_t        fu_data_i,
    output logic                     lsu_ready_o,
    output lsu_pkg::dmem_req_t       dmem_req_o,
    input  logic                     dmem_gnt_i,
    input  logic [lsu_pkg::XLEN-1:0] dmem_rdata_i,
    output lsu_pkg::lsu_result_t     load_o,
    output lsu_pkg::lsu_result_t     store_o
);
    import lsu_pkg::*;

    lsu_ctrl_t   lsu_req;
    lsu_ctrl_t   lsu_ctrl;
    logic        pop_ld;
    logic        pop_st;
    lsu_result_t ld_result;
    lsu_result_t st_result;

    // --------------------------------------------------
    // request path
    // --------------------------------------------------
    lsu_agu i_agu (
        .fu_data_i   ( fu_data_i   ),
        .lsu_valid_i ( lsu_valid_i ),
        .lsu_req_o   ( lsu_req     )
    );

    lsu_bypass i_bypass (
        .clk_i           ( clk_i       ),
        .rst_ni          ( rst_ni      ),
        .lsu_req_i       ( lsu_req     ),
        .lsu_req_valid_i ( lsu_valid_i ),
        .pop_ld_i        ( pop_ld      ),
        .pop_st_i        ( pop_st      ),
        .lsu_ctrl_o      ( lsu_ctrl    ),
        .ready_o         ( lsu_ready_o )
    );

    lsu_access i_access (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .lsu_ctrl_i   ( lsu_ctrl     ),
        .dmem_gnt_i   ( dmem_gnt_i   ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .pop_ld_o     ( pop_ld       ),
        .pop_st_o     ( pop_st       ),
        .dmem_req_o   ( dmem_req_o   ),
        .ld_result_o  ( ld_result    ),
        .st_result_o  ( st_result    )
    );

    // --------------------------------------------------
    // write-back delays
    // --------------------------------------------------
    lsu_pipe_reg #(.Depth(NR_LOAD_PIPE_REGS)) i_pipe_reg_load (
        .clk_i  ( clk_i     ),
        .rst_ni ( rst_ni    ),
        .d_i    ( ld_result ),
        .d_o    ( load_o    )
    );

    lsu_pipe_reg #(.Depth(NR_STORE_PIPE_REGS)) i_pipe_reg_store (
        .clk_i  ( clk_i     ),
        .rst_ni ( rst_ni    ),
        .d_i    ( st_result ),
        .d_o    ( store_o   )
    );

endmodule

`default_nettype wire

// File: sim/tb_load_store_unit.sv
// --------------------------------------------------
// testbench for the load/store unit
// file driven operations against a random-grant memory
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_unit;
    import lsu_pkg::*;

    logic            clk_i;
    logic            rst_ni;
    logic            lsu_valid_i;
    fu_data_t        fu_data_i;
    logic            lsu_ready_o;
    dmem_req_t       dmem_req_o;
    logic            dmem_gnt_i;
    logic [XLEN-1:0] dmem_rdata_i;
    lsu_result_t     load_o;
    lsu_result_t     store_o;

    // operations and expected records from the data file
    fu_data_t        op_q[$];
    lsu_result_t     exp_q[$];
    // records still owed by each write-back port
    lsu_result_t     load_exp_q[$];
    lsu_result_t     store_exp_q[$];

    logic [XLEN-1:0] mem [256];
    logic [7:0]      lfsr;
    // port request and grant as seen at the last rising edge
    logic            req_seen;
    logic            gnt_seen;
    int              n_granted;
    int              n_access;
    int              n_ops;
    bit              loaded;

    load_store_unit DUT (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .lsu_valid_i  ( lsu_valid_i  ),
        .fu_data_i    ( fu_data_i    ),
        .lsu_ready_o  ( lsu_ready_o  ),
        .dmem_req_o   ( dmem_req_o   ),
        .dmem_gnt_i   ( dmem_gnt_i   ),
        .dmem_rdata_i ( dmem_rdata_i ),
        .load_o       ( load_o       ),
        .store_o      ( store_o      )
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // 8-bit fibonacci lfsr with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic check(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // cause and tval only mean something for a faulting access
    task automatic compare_record(string port, lsu_result_t got, lsu_result_t exp);
        check({port, " trans_id"}, 32'(got.trans_id), 32'(exp.trans_id));
        check({port, " result"}, got.result, exp.result);
        check({port, " exception valid"}, 32'(got.ex.valid), 32'(exp.ex.valid));
        if (exp.ex.valid) begin
            check({port, " exception cause"}, got.ex.cause, exp.ex.cause);
            check({port, " exception tval"}, got.ex.tval, exp.ex.tval);
        end
    endtask

    task automatic read_testdata();
        int              fd;
        int              n;
        string           line;
        logic [31:0]     f_op, f_a, f_imm, f_b, f_id, f_exv, f_cause, f_res;
        fu_data_t        op;
        lsu_result_t     exp;
        fd = $fopen("sim/lsu_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/lsu_testdata.txt");
            $display("TEST FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_op, f_a, f_imm, f_b, f_id, f_exv, f_cause, f_res);
            // comment and blank lines give no fields
            if (n == 8) begin
                op           = '0;
                op.fu        = (f_op >= 32'd5) ? STORE : LOAD;
                op.operator  = fu_op_t'(f_op[2:0]);
                op.operand_a = f_a;
                op.operand_b = f_b;
                op.imm       = f_imm[11:0];
                op.trans_id  = f_id[TRANS_ID_BITS-1:0];
                exp          = '0;
                exp.valid    = 1'b1;
                exp.trans_id = f_id[TRANS_ID_BITS-1:0];
                exp.result   = f_res;
                exp.ex.valid = f_exv[0];
                exp.ex.cause = f_cause;
                // faulting address is operand plus sign-extended immediate
                exp.ex.tval  = f_a + {{20{f_imm[11]}}, f_imm[11:0]};
                if (!f_exv[0]) n_access++;
                op_q.push_back(op);
                exp_q.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // word-array memory model indexed by addr 9:2
    // --------------------------------------------------
    assign dmem_rdata_i = mem[dmem_req_o.addr[9:2]];

    initial begin
        logic [31:0] word;
        for (int i = 0; i < 256; i++) mem[i] <= '0;
        lfsr       = 8'd11;
        dmem_gnt_i = 1'b0;
        req_seen   = 1'b0;
        gnt_seen   = 1'b0;
        n_granted  = 0;
        forever begin
            @(posedge clk_i);
            req_seen = dmem_req_o.req;
            gnt_seen = dmem_gnt_i;
            if (req_seen && gnt_seen) begin
                n_granted++;
                // enabled lanes only
                if (dmem_req_o.we) begin
                    word = mem[dmem_req_o.addr[9:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (dmem_req_o.be[b]) word[8*b +: 8] = dmem_req_o.wdata[8*b +: 8];
                    end
                    mem[dmem_req_o.addr[9:2]] <= word;
                end
            end
            @(negedge clk_i);
            // one lfsr step per grant bit
            lfsr       = lfsr_next(lfsr);
            dmem_gnt_i = lfsr[0];
        end
    end

    // --------------------------------------------------
    // in-order write-back checker
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni && load_o.valid) begin
            if (load_exp_q.size() == 0) begin
                $display("load record %0d arrived with no load outstanding", load_o.trans_id);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                compare_record("load", load_o, load_exp_q.pop_front());
            end
        end
        if (rst_ni && store_o.valid) begin
            if (store_exp_q.size() == 0) begin
                $display("store record %0d arrived with no store outstanding", store_o.trans_id);
                $display("TEST FAILED");
                $fatal(1);
            end else begin
                compare_record("store", store_o, store_exp_q.pop_front());
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (40 * n_ops + 20) @(posedge clk_i);
        $display("timeout, operations still outstanding after %0d data lines", n_ops);
        $display("TEST FAILED");
        $fatal(1);
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        fu_data_t    op;
        lsu_result_t exp;
        logic        issued;
        logic        last_fault;
        rst_ni      = 1'b0;
        lsu_valid_i = 1'b0;
        fu_data_i   = '0;
        n_access    = 0;
        issued      = 1'b0;
        last_fault  = 1'b0;
        read_testdata();
        n_ops  = op_q.size();
        loaded = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        check("ready in reset", 32'(lsu_ready_o), 32'd1);
        check("memory request in reset", 32'(dmem_req_o.req), 32'd0);
        check("load valid in reset", 32'(load_o.valid), 32'd0);
        check("store valid in reset", 32'(store_o.valid), 32'd0);
        rst_ni = 1'b1;
        while (op_q.size() > 0 || issued) begin
            @(negedge clk_i);
            lsu_valid_i = 1'b0;
            if (issued) begin
                // a faulting op never reaches the memory port
                check("memory request on issue", 32'(req_seen), 32'(!last_fault));
                // ready stays high only if the op finished in its issue cycle
                check("ready after issue", 32'(lsu_ready_o), 32'(last_fault || gnt_seen));
            end
            issued = 1'b0;
            if (lsu_ready_o && op_q.size() > 0) begin
                op          = op_q.pop_front();
                exp         = exp_q.pop_front();
                fu_data_i   = op;
                lsu_valid_i = 1'b1;
                issued      = 1'b1;
                last_fault  = exp.ex.valid;
                if (op.fu == LOAD) load_exp_q.push_back(exp);
                else store_exp_q.push_back(exp);
            end
        end
        while (load_exp_q.size() != 0 || store_exp_q.size() != 0) @(negedge clk_i);
        // idle cycles so a stray record would still show up
        repeat (6) @(negedge clk_i);
        check("granted memory accesses", 32'(n_granted), 32'(n_access));
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/lsu_testdata.txt
// op (0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw), operand_a, imm, operand_b, trans_id
// then expected exception valid, exception cause and result, all fields in hex
7 00000100 010 deadbeef 0 0 0 00000000
4 00000120 ff0 00000000 1 0 0 deadbeef
4 00000200 000 00000000 2 0 0 00000000
7 00000000 020 11223344 3 0 0 00000000
5 00000020 001 000000aa 4 0 0 00000000
4 00000020 000 00000000 5 0 0 1122aa44
6 00000024 ffe 0000beef 6 0 0 00000000
4 00000020 000 00000000 7 0 0 beefaa44
0 00000020 001 00000000 0 0 0 ffffffaa
1 00000020 001 00000000 1 0 0 000000aa
2 00000020 002 00000000 2 0 0 ffffbeef
3 00000020 002 00000000 3 0 0 0000beef
0 00000020 000 00000000 4 0 0 00000044
2 00000020 000 00000000 5 0 0 ffffaa44
4 00000020 002 00000000 6 1 4 00000000
2 00000020 001 00000000 7 1 4 00000000
7 00000040 001 ffffffff 0 1 6 00000000
6 00000043 000 0000ffff 1 1 6 00000000
4 00000040 000 00000000 2 0 0 00000000
7 000003fc 000 cafef00d 3 0 0 00000000
0 00000400 fff 00000000 4 0 0 ffffffca
3 000003fc 000 00000000 5 0 0 0000f00d
5 000003fc 000 12345680 6 0 0 00000000
4 000003fc 000 00000000 7 0 0 cafef080
0 000003fc 000 00000000 0 0 0 ffffff80
7 00000080 7fc a5a5a5a5 1 0 0 00000000
4 00000900 f7c 00000000 2 0 0 a5a5a5a5
6 00000100 012 00007fff 3 0 0 00000000
2 00000110 002 00000000 4 0 0 00007fff
4 00000110 000 00000000 5 0 0 7fffbeef
1 0000087c 003 00000000 6 0 0 000000a5

// File: src.f
source/lsu_pkg.sv
source/lsu_agu.sv
source/lsu_bypass.sv
source/lsu_access.sv
source/lsu_pipe_reg.sv
source/load_store_unit.sv
sim/tb_load_store_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the load/store unit testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_load_store_unit -f src.f -o tb_lsu \
    && ./obj_dir/tb_lsu 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
echo "simulation passed"
exit 0
